/* src/wb_consts.svh */
`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// Bus beat and cache line geometry.
`define WB_BEAT_W       32
`define WB_LINE_BEATS   16
`define WB_ADDR_W       32

// Write-back queue depth, equal to the credits the cache starts with.
`define WB_QUEUE_DEPTH  4

// AXI encodings used on the write channels.
`define WB_AXI_SIZE_4B  3'b010
`define WB_AXI_RESP_OK  2'b00

`endif

/* src/wb_pkg.sv */
`include "wb_consts.svh"

package wb_pkg;

    typedef logic [`WB_ADDR_W-1:0]                 addr_t;
    typedef logic [`WB_BEAT_W-1:0]                 beat_t;
    typedef logic [`WB_BEAT_W*`WB_LINE_BEATS-1:0]  line_t;     // Word 0 in the low bits.
    typedef logic [$clog2(`WB_LINE_BEATS)-1:0]     beat_idx_t;
    typedef logic [1:0]                            bresp_t;

    // Request from the cache, either a dirty line or an uncached store.
    typedef struct packed {
        addr_t addr;
        line_t line;
        logic  uncache;
    } wb_req_t;

    typedef struct packed {
        addr_t      addr;
        logic [7:0] len;
        logic [2:0] size;
    } axi_aw_t;

    typedef struct packed {
        beat_t data;
        logic  last;
    } axi_w_t;

    typedef enum logic [0:0] {
        AW_IDLE,
        AW_SEND
    } aw_state_t;

    typedef enum logic [1:0] {
        SER_IDLE,
        SER_STREAM,
        SER_WAIT_B
    } ser_state_t;

endpackage

/* src/wb_req_queue.sv */
`include "wb_consts.svh"

module wb_req_queue #(
    parameter int DEPTH = `WB_QUEUE_DEPTH
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic            push,
    input  wb_pkg::wb_req_t push_req,
    input  logic            load,
    input  logic            entry_done,
    output wb_pkg::wb_req_t head,
    output logic            head_valid,
    output logic            credit_ret,
    output logic            busy
);
    import wb_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    wb_req_t            mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               open_entry;    // Popped entry still waiting for its B response.
    logic               full;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            open_entry <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (load) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, load})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            if (load) begin
                open_entry <= 1'b1;
            end else if (entry_done) begin
                open_entry <= 1'b0;
            end
        end
    end

    assign full       = (count == CNT_W'(DEPTH));
    assign head       = mem[rd_ptr];
    assign head_valid = (count != '0);
    assign credit_ret = entry_done;                 // Same cycle as the B handshake.
    assign busy       = head_valid | open_entry;

    // The cache only pushes while it holds a credit.
    a_no_push_full: assert property (@(posedge clk) disable iff (!rstn)
        push |-> !full);

    // A response only completes an entry that was handed to the bus.
    a_done_open: assert property (@(posedge clk) disable iff (!rstn)
        entry_done |-> open_entry);

endmodule

/* src/wb_aw_issue.sv */
`include "wb_consts.svh"

module wb_aw_issue (
    input  logic            clk,
    input  logic            rstn,
    input  logic            load,
    input  wb_pkg::wb_req_t head,
    output wb_pkg::axi_aw_t aw,
    output logic            awvalid,
    input  logic            awready
);
    import wb_pkg::*;

    aw_state_t state;
    axi_aw_t   aw_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= AW_IDLE;
        end else begin
            case (state)
                AW_IDLE: begin
                    if (load) begin
                        state <= AW_SEND;
                    end
                end
                AW_SEND: begin
                    if (awready) begin
                        state <= AW_IDLE;
                    end
                end
                default: state <= AW_IDLE;
            endcase
        end
    end

    // Address beat is built once per entry and held until accepted.
    always_ff @(posedge clk) begin
        if (load) begin
            aw_q.addr <= head.addr;
            aw_q.size <= `WB_AXI_SIZE_4B;
            if (head.uncache) begin
                aw_q.len <= 8'd0;                   // Single beat store.
            end else begin
                aw_q.len <= 8'(`WB_LINE_BEATS - 1);
            end
        end
    end

    assign aw      = aw_q;
    assign awvalid = (state == AW_SEND);

    // A new entry is only loaded after the previous address went out.
    a_load_idle: assert property (@(posedge clk) disable iff (!rstn)
        load |-> state == AW_IDLE);

    a_aw_stable: assert property (@(posedge clk) disable iff (!rstn)
        awvalid && !awready |=> awvalid && $stable(aw));

endmodule

/* src/wb_line_serializer.sv */
`include "wb_consts.svh"

module wb_line_serializer (
    input  logic            clk,
    input  logic            rstn,
    input  logic            head_valid,
    input  wb_pkg::wb_req_t head,
    output logic            load,
    output wb_pkg::axi_w_t  w,
    output logic            wvalid,
    input  logic            wready,
    input  logic            bvalid,
    input  wb_pkg::bresp_t  bresp,
    output logic            bready,
    output logic            entry_done,
    output logic            wr_err
);
    import wb_pkg::*;

    // Lowest address bit of the word offset within a line.
    localparam int OFF_LSB = $clog2(`WB_BEAT_W / 8);

    ser_state_t state;
    line_t      line_q;
    beat_idx_t  beat_idx;
    logic       uncache_q;
    logic       beat_ok;

    assign load    = (state == SER_IDLE) && head_valid;
    assign beat_ok = wvalid && wready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= SER_IDLE;
            beat_idx  <= '0;
            uncache_q <= 1'b0;
        end else begin
            case (state)
                SER_IDLE: begin
                    if (load) begin
                        uncache_q <= head.uncache;
                        state     <= SER_STREAM;
                        // An uncached store sends only its addressed word.
                        if (head.uncache) begin
                            beat_idx <= head.addr[OFF_LSB +: $bits(beat_idx_t)];
                        end else begin
                            beat_idx <= '0;
                        end
                    end
                end
                SER_STREAM: begin
                    if (beat_ok) begin
                        if (w.last) begin
                            state <= SER_WAIT_B;
                        end else begin
                            beat_idx <= beat_idx + 1'b1;
                        end
                    end
                end
                SER_WAIT_B: begin
                    if (bvalid) begin
                        state <= SER_IDLE;
                    end
                end
                default: state <= SER_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            line_q <= head.line;
        end
    end

    always_comb begin
        w.data = line_q[beat_idx*`WB_BEAT_W +: `WB_BEAT_W];
        w.last = uncache_q || (beat_idx == beat_idx_t'(`WB_LINE_BEATS - 1));
    end

    assign wvalid     = (state == SER_STREAM);
    assign bready     = (state == SER_WAIT_B);
    assign entry_done = bvalid && bready;
    assign wr_err     = entry_done && (bresp != `WB_AXI_RESP_OK);

    a_w_stable: assert property (@(posedge clk) disable iff (!rstn)
        wvalid && !wready |=> wvalid && $stable(w));

endmodule

/* src/wb_axi_top.sv */
module wb_axi_top (
    input  logic            clk,
    input  logic            rstn,

    input  logic            req_valid,
    input  wb_pkg::wb_req_t req,
    output logic            credit_ret,
    output logic            wr_err,
    output logic            busy,

    output wb_pkg::axi_aw_t aw,
    output logic            awvalid,
    input  logic            awready,
    output wb_pkg::axi_w_t  w,
    output logic            wvalid,
    input  logic            wready,
    input  logic            bvalid,
    input  wb_pkg::bresp_t  bresp,
    output logic            bready
);
    import wb_pkg::*;

    wb_req_t head;
    logic    head_valid;
    logic    load;
    logic    entry_done;

    wb_req_queue u_queue (
        .clk        (clk),
        .rstn       (rstn),
        .push       (req_valid),        // Credits guarantee room.
        .push_req   (req),
        .load       (load),
        .entry_done (entry_done),
        .head       (head),
        .head_valid (head_valid),
        .credit_ret (credit_ret),
        .busy       (busy)
    );

    wb_aw_issue u_aw_issue (
        .clk     (clk),
        .rstn    (rstn),
        .load    (load),
        .head    (head),
        .aw      (aw),
        .awvalid (awvalid),
        .awready (awready)
    );

    wb_line_serializer u_serializer (
        .clk        (clk),
        .rstn       (rstn),
        .head_valid (head_valid),
        .head       (head),
        .load       (load),
        .w          (w),
        .wvalid     (wvalid),
        .wready     (wready),
        .bvalid     (bvalid),
        .bresp      (bresp),
        .bready     (bready),
        .entry_done (entry_done),
        .wr_err     (wr_err)
    );

endmodule

/* verif/tb_axi_mem.sv */
`include "wb_consts.svh"

module tb_axi_mem (
    input  logic            clk,
    input  logic            rstn,
    input  wb_pkg::axi_aw_t aw,
    input  logic            awvalid,
    output logic            awready,
    input  wb_pkg::axi_w_t  w,
    input  logic            wvalid,
    output logic            wready,
    output logic            bvalid,
    output wb_pkg::bresp_t  bresp,
    input  logic            bready,
    input  logic            stall_en,
    input  logic            inject_err
);
    import wb_pkg::*;

    localparam int WORDS = 1024;        // 4 KB window, word index from addr bits 11 to 2.

    beat_t   mem [WORDS];
    axi_aw_t aw_log [$];                // Every accepted address beat, in order.
    int      last_beat_q [$];           // Beat index that carried wlast, one per burst.
    int      beat_total;

    axi_aw_t cur_aw;
    addr_t   beat_addr;
    int      beat_cnt;
    int      b_wait;
    logic    have_aw;
    logic    b_pend;
    logic    err_pend;
    logic    nx_awready;
    logic    nx_wready;
    logic    nx_bvalid;
    bresp_t  nx_bresp;

    function automatic logic accept_now();
        return !stall_en || ($urandom % 3 != 0);
    endfunction

    initial begin
        awready    = 1'b0;
        wready     = 1'b0;
        bvalid     = 1'b0;
        bresp      = 2'b00;
        beat_total = 0;
        beat_cnt   = 0;
        b_wait     = 0;
        have_aw    = 1'b0;
        b_pend     = 1'b0;
        err_pend   = 1'b0;
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = beat_t'(32'hA5A5_0000 ^ (32'(i) << 2));   // Pattern of the byte address.
        end
        forever begin
            // Handshakes are decided on the falling edge, where both sides are stable.
            @(negedge clk);
            nx_bresp = bresp;
            if (!rstn) begin
                have_aw    = 1'b0;
                b_pend     = 1'b0;
                err_pend   = 1'b0;
                nx_awready = 1'b0;
                nx_wready  = 1'b0;
                nx_bvalid  = 1'b0;
            end else begin
                if (inject_err) begin
                    err_pend = 1'b1;
                end
                if (wvalid && wready) begin
                    beat_addr = cur_aw.addr + addr_t'(4 * beat_cnt);
                    mem[beat_addr[11:2]] = w.data;
                    beat_total++;
                    if (w.last) begin
                        last_beat_q.push_back(beat_cnt);
                        have_aw = 1'b0;
                        b_pend  = 1'b1;
                        b_wait  = stall_en ? int'($urandom % 4) : 0;
                    end else begin
                        beat_cnt++;
                    end
                end
                if (awvalid && awready) begin
                    aw_log.push_back(aw);
                    cur_aw   = aw;
                    have_aw  = 1'b1;
                    beat_cnt = 0;
                end
                nx_bvalid = bvalid;
                if (bvalid && bready) begin
                    b_pend    = 1'b0;
                    nx_bvalid = 1'b0;
                end else if (b_pend && !bvalid) begin
                    if (b_wait > 0) begin
                        b_wait--;
                    end else begin
                        nx_bvalid = 1'b1;
                        nx_bresp  = err_pend ? 2'b10 : 2'b00;   // SLVERR when injected.
                        err_pend  = 1'b0;
                    end
                end
                // One burst at a time, W only after its address.
                nx_awready = !have_aw && !b_pend && accept_now();
                nx_wready  = have_aw && accept_now();
            end
            @(posedge clk);
            #1;
            awready = nx_awready;
            wready  = nx_wready;
            bvalid  = nx_bvalid;
            bresp   = nx_bresp;
        end
    end

endmodule

/* verif/tb_wb_axi.sv */
`include "wb_consts.svh"

module tb_wb_axi;
    import wb_pkg::*;

    localparam int MAX_WAIT = 2000;     // Cycles allowed per wait loop.
    localparam int WORDS    = 1024;
    localparam int N_FILL   = `WB_QUEUE_DEPTH + 2;

    logic    clk;
    logic    rstn;
    logic    req_valid;
    wb_req_t req;
    logic    credit_ret;
    logic    wr_err;
    logic    busy;
    axi_aw_t aw;
    logic    awvalid;
    logic    awready;
    axi_w_t  w;
    logic    wvalid;
    logic    wready;
    logic    bvalid;
    bresp_t  bresp;
    logic    bready;
    logic    stall_en;
    logic    inject_err;

    int      credits;
    int      done_cnt;
    int      err_cnt;
    int      stray_err;
    beat_t   ref_mem [WORDS];

    wb_axi_top dut0 (.*);

    tb_axi_mem mem0 (.*);

    always #20 clk = ~clk;

    // Credit and error pulses are counted on the falling edge.
    always @(negedge clk) begin
        if (rstn && credit_ret) begin
            credits++;
            done_cnt++;
            if (wr_err) begin
                err_cnt++;
            end
        end else if (rstn && wr_err) begin
            stray_err++;
        end
    end

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "Check failed");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timeout after %0d cycles while waiting for %s", MAX_WAIT, what);
        $display("*** TEST FAILED ***");
        $fatal(1, "Timeout");
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic reset_dut();
        rstn = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rstn = 1'b1;
    endtask

    function automatic line_t rand_line();
        line_t l;
        for (int i = 0; i < `WB_LINE_BEATS; i++) begin
            l[i*`WB_BEAT_W +: `WB_BEAT_W] = $urandom;
        end
        return l;
    endfunction

    // Expected memory effect of one request.
    task automatic expect_ref(input wb_req_t r);
        int base;
        int off;
        base = int'(r.addr[11:2]);
        off  = int'(r.addr[5:2]);
        if (r.uncache) begin
            ref_mem[base] = r.line[off*`WB_BEAT_W +: `WB_BEAT_W];
        end else begin
            for (int i = 0; i < `WB_LINE_BEATS; i++) begin
                ref_mem[base + i] = r.line[i*`WB_BEAT_W +: `WB_BEAT_W];
            end
        end
    endtask

    task automatic send_request(input wb_req_t r);
        int t;
        t = 0;
        step();
        while (credits == 0) begin
            step();
            t++;
            if (t > MAX_WAIT) timeout_fail("a free credit");
        end
        req       = r;
        req_valid = 1'b1;
        credits--;
        step();
        req_valid = 1'b0;
        expect_ref(r);
    endtask

    task automatic wait_done(input int target);
        int t;
        t = 0;
        while (done_cnt < target) begin
            @(negedge clk);
            t++;
            if (t > MAX_WAIT) timeout_fail("credit_ret");
        end
    endtask

    task automatic compare_mem();
        for (int i = 0; i < WORDS; i++) begin
            check($sformatf("memory word %0d", i), mem0.mem[i], ref_mem[i]);
        end
    endtask

    task automatic test_reset_values();
        @(negedge clk);
        check("awvalid", awvalid, 0);
        check("wvalid", wvalid, 0);
        check("bready", bready, 0);
        check("credit_ret", credit_ret, 0);
        check("wr_err", wr_err, 0);
        check("busy", busy, 0);
    endtask

    task automatic test_line_write();
        wb_req_t r;
        int      n_aw;
        int      n_last;
        int      beats;
        int      target;
        n_aw   = mem0.aw_log.size();
        n_last = mem0.last_beat_q.size();
        beats  = mem0.beat_total;
        target = done_cnt + 1;
        r.addr    = 32'h0000_0100;
        r.line    = rand_line();
        r.uncache = 1'b0;
        send_request(r);
        wait_done(target);
        check("address beats", mem0.aw_log.size(), n_aw + 1);
        check("awaddr", mem0.aw_log[n_aw].addr, r.addr);
        check("awlen", mem0.aw_log[n_aw].len, `WB_LINE_BEATS - 1);
        check("awsize", mem0.aw_log[n_aw].size, 3'b010);
        check("bursts ended by wlast", mem0.last_beat_q.size(), n_last + 1);
        check("beat with wlast", mem0.last_beat_q[n_last], `WB_LINE_BEATS - 1);
        check("data beats", mem0.beat_total - beats, `WB_LINE_BEATS);
        check("credits", credits, `WB_QUEUE_DEPTH);
        compare_mem();
    endtask

    task automatic test_uncached_store();
        wb_req_t r;
        int      n_aw;
        int      n_last;
        int      target;
        n_aw   = mem0.aw_log.size();
        n_last = mem0.last_beat_q.size();
        target = done_cnt + 1;
        r.addr    = 32'h0000_0208;      // Word 2 of its line.
        r.line    = rand_line();
        r.uncache = 1'b1;
        send_request(r);
        wait_done(target);
        check("awaddr", mem0.aw_log[n_aw].addr, r.addr);
        check("awlen", mem0.aw_log[n_aw].len, 0);
        check("bursts ended by wlast", mem0.last_beat_q.size(), n_last + 1);
        check("beat with wlast", mem0.last_beat_q[n_last], 0);
        compare_mem();
    endtask

    task automatic test_queue_fill();
        wb_req_t r;
        addr_t   addrs [N_FILL];
        int      n_aw;
        int      target;
        n_aw     = mem0.aw_log.size();
        target   = done_cnt + N_FILL;
        step();
        stall_en = 1'b1;
        for (int i = 0; i < N_FILL; i++) begin
            r.addr    = 32'h0000_0400 + addr_t'(64 * (i % (N_FILL - 1)));   // Last rewrites first.
            r.line    = rand_line();
            r.uncache = 1'b0;
            addrs[i]  = r.addr;
            send_request(r);
        end
        wait_done(target);
        step();
        stall_en = 1'b0;
        check("credits", credits, `WB_QUEUE_DEPTH);
        check("busy", busy, 0);
        check("address beats", mem0.aw_log.size(), n_aw + N_FILL);
        for (int i = 0; i < N_FILL; i++) begin
            check($sformatf("awaddr of push %0d", i), mem0.aw_log[n_aw + i].addr, addrs[i]);
        end
        compare_mem();
    endtask

    task automatic test_slave_error();
        wb_req_t r;
        int      target;
        int      errs;
        target     = done_cnt + 1;
        errs       = err_cnt;
        step();
        inject_err = 1'b1;
        step();
        inject_err = 1'b0;
        r.addr    = 32'h0000_0800;
        r.line    = rand_line();
        r.uncache = 1'b0;
        send_request(r);
        wait_done(target);
        check("wr_err with credit_ret", err_cnt, errs + 1);
        r.addr    = 32'h0000_0844;
        r.line    = rand_line();
        r.uncache = 1'b1;
        send_request(r);
        wait_done(target + 1);
        check("wr_err after recovery", err_cnt, errs + 1);
        check("credits", credits, `WB_QUEUE_DEPTH);
        compare_mem();
    endtask

    initial begin
        clk        = 1'b0;
        rstn       = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        stall_en   = 1'b0;
        inject_err = 1'b0;
        credits    = `WB_QUEUE_DEPTH;
        done_cnt   = 0;
        err_cnt    = 0;
        stray_err  = 0;
        void'($urandom(70797));
        reset_dut();
        for (int i = 0; i < WORDS; i++) begin
            ref_mem[i] = mem0.mem[i];   // Start from the slave's fill pattern.
        end
        test_reset_values();
        test_line_write();
        test_uncached_store();
        test_queue_fill();
        test_slave_error();
        if (stray_err == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("wr_err pulsed %0d times without credit_ret", stray_err);
            $display("*** TEST FAILED ***");
            $fatal(1, "Stray error pulses");
        end
    end

endmodule

/* all.f */
+incdir+src
src/wb_pkg.sv
src/wb_req_queue.sv
src/wb_aw_issue.sv
src/wb_line_serializer.sv
src/wb_axi_top.sv
verif/tb_axi_mem.sv
verif/tb_wb_axi.sv

/* run.sh */
#!/bin/sh
# Build and run the write-back testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_wb_axi \
    -f all.f -o tb_wb_axi > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_wb_axi > sim.log 2>&1
sim_status=$?
cat sim.log

grep -qF '*** TEST FAILED ***' sim.log && { echo "Simulation reported failure"; exit 1; }
[ "$sim_status" -eq 0 ] || { echo "Simulation exited with status $sim_status"; exit 1; }
echo "Simulation finished without failure"
